// File: tb.f
verilog/ooo_pkg.sv
verilog/rename_unit.sv
verilog/reservation_station.sv
verilog/execute_unit.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
sim/ooo_core_assert.sv
sim/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - verilog/ooo_pkg.sv
  - verilog/rename_unit.sv
  - verilog/reservation_station.sv
  - verilog/execute_unit.sv
  - verilog/reorder_buffer.sv
  - verilog/ooo_core.sv
  - target: simulation
    files:
      - sim/ooo_core_assert.sv
      - sim/ooo_core_tb.sv

// File: sim/ooo_core_tb.sv
`timescale 1ns/10ps

module ooo_core_tb import ooo_pkg::*; ();

    // Program length per phase
    localparam int n_probe        = arch_regs;
    localparam int n_random       = 64;
    localparam int n_chain        = 24;
    localparam int n_burst        = 24;
    localparam int num_insts      = n_probe + n_random + n_chain + n_burst;
    localparam int clk_period     = 100;
    localparam int timeout_cycles = num_insts * 20 + 50;

    logic      clock;
    logic      reset;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    logic      commit_valid;
    arch_idx_t commit_rd;
    data_t     commit_value;

    integer seed;

    // Architectural model and expected commit stream
    data_t     arch_reg [arch_regs];
    arch_idx_t exp_rd [$];
    data_t     exp_value [$];
    logic      saw_stall;

    ooo_core dut0 (
        .clock, .reset, .inst_valid, .inst, .inst_ready,
        .commit_valid, .commit_rd, .commit_value
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
            $display("** FAIL **");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("** FAIL **");
        $fatal(1, "Run aborted");
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic data_t alu_result(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    // In-order update at acceptance
    task automatic record_accept(input inst_t word);
        data_t a;
        data_t b;
        data_t v;
        a = arch_reg[word.r.rs1];
        // Immediate is zero-extended
        b = word.i.use_imm ? data_t'(word.i.imm) : arch_reg[word.r.rs2];
        v = alu_result(word.r.op, a, b);
        arch_reg[word.r.rd] = v;
        exp_rd.push_back(word.r.rd);
        exp_value.push_back(v);
    endtask

    task automatic random_inst(output inst_t word);
        logic [31:0] r;
        r = $random(seed);
        word = r[15:0];
    endtask

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send_inst(input inst_t word, input logic no_gaps);
        // Idle about one cycle in five
        while (!no_gaps && ($unsigned($random(seed)) % 5) == 0) begin
            inst_valid = 1'b0;
            @(negedge clock);
        end
        inst       = word;
        inst_valid = 1'b1;
        // Hold the word under back-pressure until taken
        while (!inst_ready) begin
            saw_stall = 1'b1;
            @(negedge clock);
        end
        // Acceptance happens at the next rising edge since inst_ready depends on state only
        record_accept(word);
        @(negedge clock);
    endtask

    // Commit monitor samples on the falling edge where outputs are stable
    always @(negedge clock) begin
        if (commit_valid === 1'b1) begin
            if (exp_rd.size() == 0) begin
                stop_run("Commit seen with no accepted instruction outstanding");
            end else begin
                check_value("commit_rd", commit_rd, exp_rd.pop_front());
                check_value("commit_value", commit_value, exp_value.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Program
    ////////////////////////////////////////////////////////////

    initial begin
        inst_t     word;
        arch_idx_t last_rd;
        seed       = 32'h7f87_9801;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        saw_stall  = 1'b0;
        last_rd    = '0;
        for (int i = 0; i < arch_regs; i++) begin
            arch_reg[i] = '0;
        end
        repeat (8) @(negedge clock);
        reset = 1'b0;

        // Idle core after reset
        check_value("commit_valid", commit_valid, 32'd0);
        check_value("inst_ready", inst_ready, 32'd1);

        // Read every register back with an add of 0
        for (int r = 0; r < n_probe; r++) begin
            word           = '0;
            word.i.use_imm = 1'b1;
            word.i.op      = op_add;
            word.i.rd      = arch_idx_t'(r);
            word.i.rs1     = arch_idx_t'(r);
            send_inst(word, 1'b0);
        end

        // Random mix with far more than 8 renames
        for (int n = 0; n < n_random; n++) begin
            random_inst(word);
            send_inst(word, 1'b0);
            last_rd = word.r.rd;
        end

        // Dependent chain through rs1
        for (int n = 0; n < n_chain; n++) begin
            random_inst(word);
            word.r.rs1 = last_rd;
            send_inst(word, 1'b0);
            last_rd = word.r.rd;
        end

        // Back-to-back serial chain lets dispatch outrun issue
        saw_stall = 1'b0;
        for (int n = 0; n < n_burst; n++) begin
            random_inst(word);
            word.r.use_imm = 1'b0;
            word.r.rs1     = last_rd;
            word.r.rs2     = last_rd;
            send_inst(word, 1'b1);
            last_rd = word.r.rd;
        end
        inst_valid = 1'b0;
        if (!saw_stall) begin
            stop_run("inst_ready never dropped during the burst");
        end

        // Drain and then watch for stray commits
        while (exp_rd.size() != 0) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);

        $display("** PASS **");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, commits did not finish", timeout_cycles);
        $display("** FAIL **");
        $fatal(1, "Timeout");
    end

endmodule

// File: sim/ooo_core_assert.sv
`timescale 1ns/10ps

module ooo_core_assert import ooo_pkg::*; (
    input logic     clock,
    input logic     reset,
    input logic     commit_valid,
    input logic     issue_valid,
    input logic     cdb_valid,
    input rob_cnt_t rob_count
);

    ////////////////////////////////////////////////////////////
    // Core state properties
    ////////////////////////////////////////////////////////////

    // Occupancy bound
    rob_count_bound: assert property (@(posedge clock) disable iff (reset)
        rob_count <= rob_cnt_t'(rob_depth))
        else $error("ROB count %0d above depth", rob_count);

    // Nothing retires right out of reset
    commit_quiet_after_reset: assert property (@(posedge clock)
        reset |=> !commit_valid)
        else $error("commit_valid high in the cycle after reset");

    // CDB register lags issue by one cycle
    cdb_after_issue: assert property (@(posedge clock) disable iff (reset)
        issue_valid |=> cdb_valid)
        else $error("Issue not broadcast on the CDB one cycle later");

    cdb_only_after_issue: assert property (@(posedge clock) disable iff (reset)
        !issue_valid |=> !cdb_valid)
        else $error("CDB broadcast without an issue the cycle before");

endmodule

bind ooo_core ooo_core_assert core_assert0 (
    .clock, .reset, .commit_valid, .issue_valid, .cdb_valid,
    .rob_count(rob0.rob_count)
);

// File: verilog/ooo_core.sv
`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    output logic      inst_ready,
    output logic      commit_valid,
    output arch_idx_t commit_rd,
    output data_t     commit_value
);

    // Dispatch
    logic      disp_fire, disp_use_imm, disp_src1_ready, disp_src2_ready;
    alu_op_t   disp_op;
    data_t     disp_imm;
    phys_tag_t disp_src1, disp_src2, disp_dest, disp_old_dest;
    arch_idx_t disp_rd;

    // Issue
    logic      issue_valid, issue_use_imm;
    alu_op_t   issue_op;
    phys_tag_t issue_src1, issue_src2, issue_dest;
    data_t     issue_imm;
    rob_idx_t  issue_rob_idx;

    // CDB and retire
    logic      cdb_valid, free_valid, rs_full, rob_full;
    phys_tag_t cdb_tag, free_tag;
    rob_idx_t  cdb_rob_idx, rob_tail, rob_head;
    data_t     cdb_value;

    rename_unit rename0 (
        .clock, .reset, .inst_valid, .inst, .rs_full, .rob_full,
        .cdb_valid, .cdb_tag, .free_valid, .free_tag,
        .inst_ready, .disp_fire, .disp_op, .disp_use_imm, .disp_imm,
        .disp_src1, .disp_src1_ready, .disp_src2, .disp_src2_ready,
        .disp_dest, .disp_old_dest, .disp_rd
    );

    // ROB head drives the age compare in the station
    reservation_station rs0 (
        .clock, .reset, .disp_fire, .disp_op, .disp_use_imm, .disp_imm,
        .disp_src1, .disp_src1_ready, .disp_src2, .disp_src2_ready,
        .disp_dest, .rob_tail, .rs_head(rob_head), .cdb_valid, .cdb_tag,
        .rs_full, .issue_valid, .issue_op, .issue_src1, .issue_src2,
        .issue_use_imm, .issue_imm, .issue_dest, .issue_rob_idx
    );

    execute_unit exe0 (
        .clock, .reset, .issue_valid, .issue_op, .issue_src1, .issue_src2,
        .issue_use_imm, .issue_imm, .issue_dest, .issue_rob_idx,
        .cdb_valid, .cdb_tag, .cdb_rob_idx, .cdb_value
    );

    reorder_buffer rob0 (
        .clock, .reset, .disp_fire, .disp_dest, .disp_old_dest, .disp_rd,
        .cdb_valid, .cdb_rob_idx, .cdb_value,
        .rob_full, .rob_tail, .rob_head, .commit_valid, .commit_rd,
        .commit_value, .free_valid, .free_tag
    );

endmodule

// File: verilog/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      disp_fire,
    input  phys_tag_t disp_dest,
    input  phys_tag_t disp_old_dest,
    input  arch_idx_t disp_rd,
    input  logic      cdb_valid,
    input  rob_idx_t  cdb_rob_idx,
    input  data_t     cdb_value,
    output logic      rob_full,
    output rob_idx_t  rob_tail,
    output rob_idx_t  rob_head,
    output logic      commit_valid,
    output arch_idx_t commit_rd,
    output data_t     commit_value,
    output logic      free_valid,
    output phys_tag_t free_tag
);

    // Entry payload
    logic [rob_depth-1:0] e_done;
    data_t     e_value    [rob_depth];
    phys_tag_t e_old_dest [rob_depth];
    arch_idx_t e_rd       [rob_depth];

    // Circular buffer pointers
    rob_idx_t head;
    rob_idx_t tail;
    rob_cnt_t rob_count;

    logic retire;

    assign rob_full = rob_count == rob_cnt_t'(rob_depth);
    assign rob_tail = tail;
    assign rob_head = head;

    ////////////////////////////////////////////////////////////
    // Retire
    ////////////////////////////////////////////////////////////

    // Head retires as soon as its result is in
    assign retire       = (rob_count != '0) && e_done[head];
    assign commit_valid = retire;
    assign commit_rd    = e_rd[head];
    assign commit_value = e_value[head];

    // Previous mapping of rd goes back to the free list
    assign free_valid = retire;
    assign free_tag   = e_old_dest[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            rob_count <= '0;
        end else begin
            if (disp_fire) tail <= tail + 1'b1;
            if (retire) head <= head + 1'b1;
            rob_count <= rob_count + rob_cnt_t'(disp_fire) - rob_cnt_t'(retire);
        end
    end

    // Allocate at the tail and complete from the CDB
    always_ff @(posedge clock) begin
        if (disp_fire) begin
            e_done[tail]     <= 1'b0;
            e_old_dest[tail] <= disp_old_dest;
            e_rd[tail]       <= disp_rd;
        end
        if (cdb_valid) begin
            e_done[cdb_rob_idx]  <= 1'b1;
            e_value[cdb_rob_idx] <= cdb_value;
        end
    end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/10ps

module execute_unit import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      issue_valid,
    input  alu_op_t   issue_op,
    input  phys_tag_t issue_src1,
    input  phys_tag_t issue_src2,
    input  logic      issue_use_imm,
    input  data_t     issue_imm,
    input  phys_tag_t issue_dest,
    input  rob_idx_t  issue_rob_idx,
    output logic      cdb_valid,
    output phys_tag_t cdb_tag,
    output rob_idx_t  cdb_rob_idx,
    output data_t     cdb_value
);

    // Physical register file
    data_t prf [phys_regs];

    data_t opa;
    data_t opb;
    data_t result;

    ////////////////////////////////////////////////////////////
    // Operand read and ALU
    ////////////////////////////////////////////////////////////

    // Bypass the value the CDB is writing this cycle
    assign opa = (cdb_valid && cdb_tag == issue_src1) ? cdb_value : prf[issue_src1];

    always_comb begin
        if (issue_use_imm) begin
            opb = issue_imm;
        end else if (cdb_valid && cdb_tag == issue_src2) begin
            opb = cdb_value;
        end else begin
            opb = prf[issue_src2];
        end
    end

    always_comb begin
        case (issue_op)
            op_add:  result = opa + opb;
            op_sub:  result = opa - opb;
            op_and:  result = opa & opb;
            default: result = opa ^ opb;
        endcase
    end

    // CDB register runs one cycle behind issue
    always_ff @(posedge clock) begin
        if (reset) cdb_valid <= 1'b0;
        else cdb_valid <= issue_valid;
        cdb_tag     <= issue_dest;
        cdb_rob_idx <= issue_rob_idx;
        cdb_value   <= result;
    end

    // Architectural state starts at zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) prf[i] <= '0;
        end else if (cdb_valid) begin
            prf[cdb_tag] <= cdb_value;
        end
    end

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/10ps

module reservation_station import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      disp_fire,
    input  alu_op_t   disp_op,
    input  logic      disp_use_imm,
    input  data_t     disp_imm,
    input  phys_tag_t disp_src1,
    input  logic      disp_src1_ready,
    input  phys_tag_t disp_src2,
    input  logic      disp_src2_ready,
    input  phys_tag_t disp_dest,
    input  rob_idx_t  rob_tail,
    input  rob_idx_t  rs_head,
    input  logic      cdb_valid,
    input  phys_tag_t cdb_tag,
    output logic      rs_full,
    output logic      issue_valid,
    output alu_op_t   issue_op,
    output phys_tag_t issue_src1,
    output phys_tag_t issue_src2,
    output logic      issue_use_imm,
    output data_t     issue_imm,
    output phys_tag_t issue_dest,
    output rob_idx_t  issue_rob_idx
);

    // Entry storage
    logic [rs_depth-1:0] e_valid;
    logic [rs_depth-1:0] e_rdy1;
    logic [rs_depth-1:0] e_rdy2;
    alu_op_t   e_op      [rs_depth];
    logic      e_use_imm [rs_depth];
    data_t     e_imm     [rs_depth];
    phys_tag_t e_src1    [rs_depth];
    phys_tag_t e_src2    [rs_depth];
    phys_tag_t e_dest    [rs_depth];
    rob_idx_t  e_rob     [rs_depth];

    rs_idx_t alloc_idx;
    rs_idx_t issue_idx;

    assign rs_full = &e_valid;

    // Lowest free slot takes the next dispatch
    always_comb begin
        alloc_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!e_valid[i]) alloc_idx = rs_idx_t'(i);
        end
    end

    ////////////////////////////////////////////////////////////
    // Oldest-ready select
    ////////////////////////////////////////////////////////////

    // Age is the distance of the ROB index from the ROB head
    always_comb begin
        rob_idx_t age;
        rob_idx_t best_age;
        issue_valid = 1'b0;
        issue_idx   = '0;
        best_age    = '1;
        for (int i = 0; i < rs_depth; i++) begin
            age = e_rob[i] - rs_head;
            if (e_valid[i] && e_rdy1[i] && e_rdy2[i] && (!issue_valid || age < best_age)) begin
                issue_valid = 1'b1;
                issue_idx   = rs_idx_t'(i);
                best_age    = age;
            end
        end
    end

    assign issue_op      = e_op[issue_idx];
    assign issue_src1    = e_src1[issue_idx];
    assign issue_src2    = e_src2[issue_idx];
    assign issue_use_imm = e_use_imm[issue_idx];
    assign issue_imm     = e_imm[issue_idx];
    assign issue_dest    = e_dest[issue_idx];
    assign issue_rob_idx = e_rob[issue_idx];

    // Occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            e_valid <= '0;
        end else begin
            if (issue_valid) e_valid[issue_idx] <= 1'b0;
            if (disp_fire) e_valid[alloc_idx] <= 1'b1;
        end
    end

    // Wakeup on CDB match, then fill the allocated slot
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb_valid && e_src1[i] == cdb_tag) e_rdy1[i] <= 1'b1;
            if (cdb_valid && e_src2[i] == cdb_tag) e_rdy2[i] <= 1'b1;
        end
        if (disp_fire) begin
            e_op[alloc_idx]      <= disp_op;
            e_use_imm[alloc_idx] <= disp_use_imm;
            e_imm[alloc_idx]     <= disp_imm;
            e_src1[alloc_idx]    <= disp_src1;
            e_src2[alloc_idx]    <= disp_src2;
            e_rdy1[alloc_idx]    <= disp_src1_ready;
            e_rdy2[alloc_idx]    <= disp_src2_ready;
            e_dest[alloc_idx]    <= disp_dest;
            e_rob[alloc_idx]     <= rob_tail;
        end
    end

endmodule

// File: verilog/rename_unit.sv
`timescale 1ns/10ps

module rename_unit import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      inst_valid,
    input  inst_t     inst,
    input  logic      rs_full,
    input  logic      rob_full,
    input  logic      cdb_valid,
    input  phys_tag_t cdb_tag,
    input  logic      free_valid,
    input  phys_tag_t free_tag,
    output logic      inst_ready,
    output logic      disp_fire,
    output alu_op_t   disp_op,
    output logic      disp_use_imm,
    output data_t     disp_imm,
    output phys_tag_t disp_src1,
    output logic      disp_src1_ready,
    output phys_tag_t disp_src2,
    output logic      disp_src2_ready,
    output phys_tag_t disp_dest,
    output phys_tag_t disp_old_dest,
    output arch_idx_t disp_rd
);

    // Speculative map and per-tag ready bits
    phys_tag_t map_table [arch_regs];
    logic [phys_regs-1:0] tag_ready;

    // Free list FIFO
    phys_tag_t free_fifo [free_depth];
    free_ptr_t free_head;
    free_ptr_t free_tail;
    free_cnt_t free_cnt;

    // Accept only when every downstream structure has room
    assign inst_ready = (free_cnt != '0) && !rs_full && !rob_full;
    assign disp_fire  = inst_valid && inst_ready;

    ////////////////////////////////////////////////////////////
    // Decode and rename
    ////////////////////////////////////////////////////////////

    assign disp_op      = inst.r.op;
    assign disp_use_imm = inst.i.use_imm;
    assign disp_imm     = data_t'(inst.i.imm);
    assign disp_rd      = inst.r.rd;

    assign disp_src1     = map_table[inst.r.rs1];
    assign disp_src2     = map_table[inst.r.rs2];
    assign disp_dest     = free_fifo[free_head];
    assign disp_old_dest = map_table[inst.r.rd];

    // Catch a tag that the CDB broadcasts in this very cycle
    assign disp_src1_ready = tag_ready[disp_src1] || (cdb_valid && cdb_tag == disp_src1);
    // Immediate form has no second register source
    assign disp_src2_ready = disp_use_imm || tag_ready[disp_src2]
                           || (cdb_valid && cdb_tag == disp_src2);

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, everything ready, upper tags free
            for (int i = 0; i < arch_regs; i++) begin
                map_table[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < free_depth; i++) begin
                free_fifo[i] <= phys_tag_t'(arch_regs + i);
            end
            tag_ready <= '1;
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= free_cnt_t'(free_depth);
        end else begin
            if (cdb_valid) begin
                tag_ready[cdb_tag] <= 1'b1;
            end
            if (disp_fire) begin
                map_table[disp_rd]   <= disp_dest;
                tag_ready[disp_dest] <= 1'b0;
                free_head            <= free_head + 1'b1;
            end
            // Retired instruction hands back its previous tag
            if (free_valid) begin
                free_fifo[free_tail] <= free_tag;
                free_tail            <= free_tail + 1'b1;
            end
            free_cnt <= free_cnt + free_cnt_t'(free_valid) - free_cnt_t'(disp_fire);
        end
    end

endmodule

// File: verilog/ooo_pkg.sv
package ooo_pkg;

    ////////////////////////////////////////////////////////////
    // Machine sizes
    ////////////////////////////////////////////////////////////

    localparam int arch_regs  = 8;
    localparam int phys_regs  = 16;
    localparam int rob_depth  = 8;
    localparam int rs_depth   = 4;
    localparam int data_width = 16;

    // Tags not held by the architectural state at any time
    localparam int free_depth = phys_regs - arch_regs;

    typedef logic [$clog2(arch_regs)-1:0]    arch_idx_t;
    typedef logic [$clog2(phys_regs)-1:0]    phys_tag_t;
    typedef logic [$clog2(rob_depth)-1:0]    rob_idx_t;
    typedef logic [$clog2(rob_depth+1)-1:0]  rob_cnt_t;
    typedef logic [$clog2(rs_depth)-1:0]     rs_idx_t;
    typedef logic [$clog2(free_depth)-1:0]   free_ptr_t;
    typedef logic [$clog2(free_depth+1)-1:0] free_cnt_t;
    typedef logic [data_width-1:0]           data_t;

    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_and = 2'b10,
        op_xor = 2'b11
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////

    // Register-register view
    typedef struct packed {
        logic      use_imm;
        alu_op_t   op;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        logic [3:0] spare;
    } inst_r_t;

    // Register-immediate view, imm is zero-extended
    typedef struct packed {
        logic       use_imm;
        alu_op_t    op;
        arch_idx_t  rd;
        arch_idx_t  rs1;
        logic [6:0] imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

endpackage
